//--- run.sh
#!/bin/sh
# Compile and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module branch_unit_tb -Mdir obj_dir

# The sim may stop early, the log decides the result
./obj_dir/Vbranch_unit_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: pass"
    exit 0
fi
echo "run.sh: fail"
exit 1

//--- src/branch_cfg_if.sv
`timescale 1ns/1ps

// Dispatcher to slot bus, shared by every slot
interface branch_cfg_if;

    // Configuration write, one-hot over slots
    logic [branch_pkg::slot_count-1:0]   wr_en;
    branch_pkg::cfg_field_e              wr_field;
    logic [branch_pkg::thread_width-1:0] wr_thread;
    logic [branch_pkg::word_width-1:0]   wr_data;

    // Accepted result word
    logic                                rd_valid;
    logic [branch_pkg::thread_width-1:0] rd_thread;
    logic [branch_pkg::word_width-1:0]   rd_data;

    // Driving side
    modport dispatch (
        output wr_en, wr_field, wr_thread, wr_data,
        output rd_valid, rd_thread, rd_data
    );

    // Receiving side
    // Write enable left out, each slot gets its own bit at the generate site
    modport slot (
        input wr_field, wr_thread, wr_data,
        input rd_valid, rd_thread, rd_data
    );

endinterface

//--- src/branch_dispatch.sv
`timescale 1ns/1ps

module branch_dispatch (
    input  logic                                clock,
    input  logic                                rst_n,

    // Result words from the processor
    input  logic                                r_valid,
    input  logic [branch_pkg::thread_width-1:0] r_thread,
    input  logic [branch_pkg::word_width-1:0]   r_data,

    // Configuration writes
    input  logic                                cfg_wren,
    input  logic [branch_pkg::slot_width-1:0]   cfg_slot,
    input  branch_pkg::cfg_field_e              cfg_field,
    input  logic [branch_pkg::thread_width-1:0] cfg_thread,
    input  logic [branch_pkg::word_width-1:0]   cfg_data,

    // Toward the slots
    branch_cfg_if.dispatch                      cfg
);

    // Decoded slot select
    logic [branch_pkg::slot_count-1:0] slot_onehot;

    // ----------------------------------------
    // Slot decode
    // ----------------------------------------

    // One bit per slot, so no slot carries its own index
    always_comb begin
        slot_onehot = '0;
        slot_onehot[cfg_slot] = 1'b1;
    end

    // ----------------------------------------
    // Control register
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cfg.wr_en    <= '0;
            cfg.rd_valid <= 1'b0;
        end else begin
            // Idle write enable is all zero
            cfg.wr_en    <= cfg_wren ? slot_onehot : '0;
            // Every offered word is accepted, credits keep it safe
            cfg.rd_valid <= r_valid;
        end
    end

    // ----------------------------------------
    // Payload register
    // ----------------------------------------

    always_ff @(posedge clock) begin
        // Config payload follows the enable
        cfg.wr_field  <= cfg_field;
        cfg.wr_thread <= cfg_thread;
        cfg.wr_data   <= cfg_data;
        // Result payload only moves on a valid word
        if (r_valid) begin
            cfg.rd_thread <= r_thread;
            cfg.rd_data   <= r_data;
        end
    end

endmodule

//--- src/branch_pkg.sv
package branch_pkg;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------

    // Result word, sentinel and mask all share one width
    localparam int word_width = 32;

    // Barrel threads
    localparam int thread_count = 8;
    localparam int thread_width = 3;

    // Branch slots, all identical
    localparam int slot_count = 4;
    localparam int slot_width = 2;

    // ----------------------------------------
    // Flow control
    // ----------------------------------------

    // Upstream credits after reset
    // Also the result queue depth, kept a power of two
    localparam int in_credits = 4;

    // Ceiling on consumer grants held at once
    localparam int out_credits = 4;

    // Queue pointer and occupancy widths
    localparam int queue_ptr_width = $clog2(in_credits);
    localparam int queue_cnt_width = $clog2(in_credits + 1);

    // Output credit counter reaches out_credits
    localparam int credit_width = $clog2(out_credits + 1);

    // ----------------------------------------
    // Configuration
    // ----------------------------------------

    // Target table of a configuration write
    typedef enum logic [0:0] {
        cfg_sentinel = 1'b0,
        cfg_mask     = 1'b1
    } cfg_field_e;

endpackage

//--- src/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic                                clock,
    input  logic                                rst_n,

    // From the slots
    input  logic [branch_pkg::slot_count-1:0]   match,
    input  logic [branch_pkg::slot_count-1:0]   match_valid,
    input  logic [branch_pkg::thread_width-1:0] match_thread,

    // Credit flow
    input  logic                                out_credit,
    output logic                                r_credit,

    // Decision to the consumer
    output logic                                branch_valid,
    output logic                                branch_taken,
    output logic [branch_pkg::slot_width-1:0]   branch_slot,
    output logic [branch_pkg::thread_width-1:0] branch_thread
);

    // Priority pick
    logic                                push;
    logic                                pick_taken;
    logic [branch_pkg::slot_width-1:0]   pick_slot;

    // Result queue storage
    logic                                q_taken  [branch_pkg::in_credits];
    logic [branch_pkg::slot_width-1:0]   q_slot   [branch_pkg::in_credits];
    logic [branch_pkg::thread_width-1:0] q_thread [branch_pkg::in_credits];

    // Queue control
    logic [branch_pkg::queue_ptr_width-1:0] wr_ptr;
    logic [branch_pkg::queue_ptr_width-1:0] rd_ptr;
    logic [branch_pkg::queue_cnt_width-1:0] q_count;
    logic                                   pop;

    // Consumer grants on hand
    logic [branch_pkg::credit_width-1:0]    credit_count;

    // ----------------------------------------
    // Lowest matching slot
    // ----------------------------------------

    // All slots run in lockstep, valid bits agree
    assign push = &match_valid;

    always_comb begin
        pick_taken = 1'b0;
        pick_slot  = '0;
        // Walk down so the lowest index is written last
        for (int i = branch_pkg::slot_count - 1; i >= 0; i--) begin
            if (match[i]) begin
                pick_taken = 1'b1;
                pick_slot  = branch_pkg::slot_width'(i);
            end
        end
    end

    // ----------------------------------------
    // Result queue
    // ----------------------------------------

    // Input credits bound occupancy, no full check needed
    always_ff @(posedge clock) begin
        if (push) begin
            q_taken[wr_ptr]  <= pick_taken;
            q_slot[wr_ptr]   <= pick_slot;
            q_thread[wr_ptr] <= match_thread;
        end
    end

    // Leave only with a result queued and a grant held
    assign pop = (q_count != '0) && (credit_count != '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            // Pointers wrap on their own
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            q_count <= q_count + branch_pkg::queue_cnt_width'(push)
                               - branch_pkg::queue_cnt_width'(pop);
        end
    end

    // ----------------------------------------
    // Output credits
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            credit_count <= '0;
        end else begin
            // Grant and spend can land together
            credit_count <= credit_count + branch_pkg::credit_width'(out_credit)
                                         - branch_pkg::credit_width'(pop);
        end
    end

    // Head of queue straight to the consumer
    assign branch_valid  = pop;
    assign branch_taken  = q_taken[rd_ptr];
    assign branch_slot   = q_slot[rd_ptr];
    assign branch_thread = q_thread[rd_ptr];

    // One upstream credit back per departing result
    assign r_credit = pop;

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                                clock,
    input  logic                                rst_n,

    // Upstream
    input  logic                                r_valid,
    input  logic [branch_pkg::thread_width-1:0] r_thread,
    input  logic [branch_pkg::word_width-1:0]   r_data,
    output logic                                r_credit,

    // Configuration
    input  logic                                cfg_wren,
    input  logic [branch_pkg::slot_width-1:0]   cfg_slot,
    input  branch_pkg::cfg_field_e              cfg_field,
    input  logic [branch_pkg::thread_width-1:0] cfg_thread,
    input  logic [branch_pkg::word_width-1:0]   cfg_data,

    // Consumer
    output logic                                branch_valid,
    output logic                                branch_taken,
    output logic [branch_pkg::slot_width-1:0]   branch_slot,
    output logic [branch_pkg::thread_width-1:0] branch_thread,
    input  logic                                out_credit
);

    // Dispatcher to slots
    branch_cfg_if cfg_bus ();

    // Slots to resolver, one bit each
    logic [branch_pkg::slot_count-1:0]   slot_match;
    logic [branch_pkg::slot_count-1:0]   slot_valid;

    // Thread number beside the slot pipeline
    logic [branch_pkg::thread_width-1:0] thread_d1;
    logic [branch_pkg::thread_width-1:0] thread_d2;

    // ----------------------------------------
    // Dispatch
    // ----------------------------------------

    branch_dispatch u_dispatch (
        .clock      (clock),
        .rst_n      (rst_n),
        .r_valid    (r_valid),
        .r_thread   (r_thread),
        .r_data     (r_data),
        .cfg_wren   (cfg_wren),
        .cfg_slot   (cfg_slot),
        .cfg_field  (cfg_field),
        .cfg_thread (cfg_thread),
        .cfg_data   (cfg_data),
        .cfg        (cfg_bus)
    );

    // ----------------------------------------
    // Slots
    // ----------------------------------------

    genvar i;
    generate
        for (i = 0; i < branch_pkg::slot_count; i++) begin : g_slot
            // Each slot sees only its own write enable
            sentinel_slot u_slot (
                .clock       (clock),
                .rst_n       (rst_n),
                .cfg         (cfg_bus),
                .slot_sel    (cfg_bus.wr_en[i]),
                .match       (slot_match[i]),
                .match_valid (slot_valid[i])
            );
        end
    endgenerate

    // Two stages to match table read and compare register
    always_ff @(posedge clock) begin
        thread_d1 <= cfg_bus.rd_thread;
        thread_d2 <= thread_d1;
    end

    // ----------------------------------------
    // Resolve
    // ----------------------------------------

    branch_resolve u_resolve (
        .clock         (clock),
        .rst_n         (rst_n),
        .match         (slot_match),
        .match_valid   (slot_valid),
        .match_thread  (thread_d2),
        .out_credit    (out_credit),
        .r_credit      (r_credit),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_slot   (branch_slot),
        .branch_thread (branch_thread)
    );

endmodule

//--- src/sentinel_slot.sv
`timescale 1ns/1ps

module sentinel_slot (
    input  logic       clock,
    input  logic       rst_n,

    // Shared dispatcher bus
    branch_cfg_if.slot cfg,

    // This slot's write enable bit
    input  logic       slot_sel,

    // Registered compare result
    output logic       match,
    output logic       match_valid
);

    // Per-thread tables, undefined until configured
    logic [branch_pkg::word_width-1:0] sentinel_mem [branch_pkg::thread_count];
    logic [branch_pkg::word_width-1:0] mask_mem     [branch_pkg::thread_count];

    // Read stage
    logic [branch_pkg::word_width-1:0] sentinel_q;
    logic [branch_pkg::word_width-1:0] mask_q;
    logic [branch_pkg::word_width-1:0] data_q;
    logic                              valid_q;

    // Compare result before the output register
    logic                              hit;

    // ----------------------------------------
    // Table writes
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (slot_sel) begin
            // Field picks the table, thread picks the word
            if (cfg.wr_field == branch_pkg::cfg_sentinel) begin
                sentinel_mem[cfg.wr_thread] <= cfg.wr_data;
            end else begin
                mask_mem[cfg.wr_thread] <= cfg.wr_data;
            end
        end
    end

    // ----------------------------------------
    // Registered read
    // ----------------------------------------

    // Same-edge write returns old contents
    always_ff @(posedge clock) begin
        sentinel_q <= sentinel_mem[cfg.rd_thread];
        mask_q     <= mask_mem[cfg.rd_thread];
        // Word delayed to line up with table data
        data_q     <= cfg.rd_data;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cfg.rd_valid;
        end
    end

    // ----------------------------------------
    // Masked equality
    // ----------------------------------------

    // Only bits set in the mask must agree
    assign hit = ((data_q ^ sentinel_q) & mask_q) == '0;

    // Output register, lets a new word enter every cycle
    always_ff @(posedge clock) begin
        match <= hit;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            match_valid <= 1'b0;
        end else begin
            match_valid <= valid_q;
        end
    end

endmodule

//--- include/branch_tb_vectors.svh
`ifndef branch_tb_vectors_svh
`define branch_tb_vectors_svh

// ----------------------------------------
// Stimulus and expected-value table
// ----------------------------------------

localparam int max_rows = 160;

// One configuration write or one result word per row
logic                                row_is_cfg [max_rows];
logic [branch_pkg::slot_width-1:0]   row_slot   [max_rows];
branch_pkg::cfg_field_e              row_field  [max_rows];
logic [branch_pkg::thread_width-1:0] row_thread [max_rows];
logic [branch_pkg::word_width-1:0]   row_data   [max_rows];

// Expected decision, result rows only
logic                                exp_taken  [max_rows];
logic [branch_pkg::slot_width-1:0]   exp_slot   [max_rows];
int                                  row_count;
int                                  result_rows;

// Reference copies of every slot's tables
logic [branch_pkg::word_width-1:0]
    ref_sentinel [branch_pkg::slot_count][branch_pkg::thread_count];
logic [branch_pkg::word_width-1:0]
    ref_mask     [branch_pkg::slot_count][branch_pkg::thread_count];

// Unique starting sentinel per slot and thread
function automatic logic [31:0] default_sentinel(input int slot, input int thread);
    return 32'hA500_003C | (32'(slot) << 16) | (32'(thread) << 8);
endfunction

// Config row, mirrored into the reference tables
task automatic add_config(input int slot, input branch_pkg::cfg_field_e field,
                          input int thread, input logic [31:0] data);
    row_is_cfg[row_count] = 1'b1;
    row_slot[row_count]   = branch_pkg::slot_width'(slot);
    row_field[row_count]  = field;
    row_thread[row_count] = branch_pkg::thread_width'(thread);
    row_data[row_count]   = data;
    if (field == branch_pkg::cfg_sentinel) begin
        ref_sentinel[slot][thread] = data;
    end else begin
        ref_mask[slot][thread] = data;
    end
    row_count++;
endtask

// Result row with its predicted decision
task automatic add_result(input int thread, input logic [31:0] data);
    logic found;
    found = 1'b0;
    row_is_cfg[row_count] = 1'b0;
    row_thread[row_count] = branch_pkg::thread_width'(thread);
    row_data[row_count]   = data;
    exp_slot[row_count]   = '0;
    // First slot, counting up, where the masked bits agree
    for (int s = 0; s < branch_pkg::slot_count; s++) begin
        if (!found && (data & ref_mask[s][thread]) ==
                      (ref_sentinel[s][thread] & ref_mask[s][thread])) begin
            found = 1'b1;
            exp_slot[row_count] = branch_pkg::slot_width'(s);
        end
    end
    exp_taken[row_count] = found;
    result_rows++;
    row_count++;
endtask

task automatic fill_vector_table();
    int          thread;
    int          slot;
    logic [31:0] word;
    row_count   = 0;
    result_rows = 0;
    // Known state everywhere, exact match on a unique word
    for (int s = 0; s < branch_pkg::slot_count; s++) begin
        for (int t = 0; t < branch_pkg::thread_count; t++) begin
            add_config(s, branch_pkg::cfg_sentinel, t, default_sentinel(s, t));
            add_config(s, branch_pkg::cfg_mask, t, 32'hFFFF_FFFF);
        end
    end
    // Zero mask on thread 0, slot 0 always wins
    for (int s = 0; s < branch_pkg::slot_count; s++) begin
        add_config(s, branch_pkg::cfg_mask, 0, 32'h0);
    end
    add_result(0, 32'h0000_0000);
    add_result(0, 32'hFFFF_FFFF);
    add_result(0, 32'h1357_9BDF);
    // Exact sentinel, one bit off misses
    add_config(2, branch_pkg::cfg_sentinel, 1, 32'hDEAD_BEEF);
    add_result(1, 32'hDEAD_BEEF);
    add_result(1, 32'hDEAD_BEEE);
    add_result(1, 32'h5EAD_BEEF);
    // Partial masks on thread 2, slots 1 and 3 overlap
    add_config(1, branch_pkg::cfg_sentinel, 2, 32'h0000_1200);
    add_config(1, branch_pkg::cfg_mask, 2, 32'h0000_FF00);
    add_config(3, branch_pkg::cfg_sentinel, 2, 32'h0000_0200);
    add_config(3, branch_pkg::cfg_mask, 2, 32'h0000_0F00);
    add_result(2, 32'hFFFF_12FF);
    add_result(2, 32'h0000_3200);
    add_result(2, 32'h1234_5678);
    // Thread 3 write must not leak into thread 4
    add_config(0, branch_pkg::cfg_sentinel, 3, 32'h5555_5555);
    add_result(4, 32'h5555_5555);
    add_result(3, 32'h5555_5555);
    add_result(5, default_sentinel(1, 4));
    add_result(4, default_sentinel(1, 4));
    // Random burst, about half aimed at a stored sentinel
    for (int n = 0; n < 64; n++) begin
        thread = $urandom_range(branch_pkg::thread_count - 1, 0);
        slot   = $urandom_range(branch_pkg::slot_count - 1, 0);
        word   = $urandom;
        if ($urandom_range(1, 0) == 1) begin
            word = ref_sentinel[slot][thread] ^ (word & ~ref_mask[slot][thread]);
        end
        add_result(thread, word);
    end
endtask

`endif

//--- test/branch_unit_tb.sv
`timescale 1ns/1ps

module branch_unit_tb;

    // 4 ns clock
    localparam int half_period    = 2;
    localparam int reset_cycles   = 4;
    localparam int cycles_per_row = 20;

    logic                                clock;
    logic                                rst_n;
    logic                                r_valid;
    logic [branch_pkg::thread_width-1:0] r_thread;
    logic [branch_pkg::word_width-1:0]   r_data;
    logic                                r_credit;
    logic                                cfg_wren;
    logic [branch_pkg::slot_width-1:0]   cfg_slot;
    branch_pkg::cfg_field_e              cfg_field;
    logic [branch_pkg::thread_width-1:0] cfg_thread;
    logic [branch_pkg::word_width-1:0]   cfg_data;
    logic                                branch_valid;
    logic                                branch_taken;
    logic [branch_pkg::slot_width-1:0]   branch_slot;
    logic [branch_pkg::thread_width-1:0] branch_thread;
    logic                                out_credit;

    // Driver and checker bookkeeping
    logic        table_ready;
    int          words_sent;
    int          credits_returned;
    int          results_seen;

    `include "branch_tb_vectors.svh"

    branch_unit u_branch_unit (.*);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_run($sformatf("CHECK FAILED: %s = 0x%0h, expected 0x%0h", name, got, want));
    endtask

    // ----------------------------------------
    // Driver
    // ----------------------------------------

    // Result rows wait for an upstream credit and config rows never do
    task automatic drive_row(input int row);
        @(posedge clock);
        while (!row_is_cfg[row] && words_sent - credits_returned >= branch_pkg::in_credits) begin
            r_valid  <= 1'b0;
            cfg_wren <= 1'b0;
            @(posedge clock);
        end
        if (row_is_cfg[row]) begin
            cfg_wren   <= 1'b1;
            cfg_slot   <= row_slot[row];
            cfg_field  <= row_field[row];
            cfg_thread <= row_thread[row];
            cfg_data   <= row_data[row];
            r_valid    <= 1'b0;
        end else begin
            r_valid  <= 1'b1;
            r_thread <= row_thread[row];
            r_data   <= row_data[row];
            cfg_wren <= 1'b0;
            words_sent++;
        end
    endtask

    initial begin
        int credits_held;
        void'($urandom(32'h3281_3876));
        table_ready = 1'b0;
        words_sent  = 0;
        rst_n       = 1'b0;
        r_valid     = 1'b0;
        r_thread    = '0;
        r_data      = '0;
        cfg_wren    = 1'b0;
        cfg_slot    = '0;
        cfg_field   = branch_pkg::cfg_sentinel;
        cfg_thread  = '0;
        cfg_data    = '0;
        fill_vector_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
        for (int row = 0; row < row_count; row++) begin
            drive_row(row);
        end
        @(posedge clock);
        r_valid  <= 1'b0;
        cfg_wren <= 1'b0;
        // Drain then idle to catch any stray result
        wait (results_seen == result_rows);
        repeat (10) @(posedge clock);
        // Upstream should hold its full credit count again
        credits_held = branch_pkg::in_credits - words_sent + credits_returned;
        assert (credits_held == branch_pkg::in_credits) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_mismatch("upstream credits", 32'(credits_held),
                            32'(branch_pkg::in_credits));
        end
    end

    // ----------------------------------------
    // Consumer, checker, cycle limit
    // ----------------------------------------

    initial begin
        int expected_rows[$];
        int held;
        int row;
        int cycles;
        held             = 0;
        cycles           = 0;
        credits_returned = 0;
        results_seen     = 0;
        out_credit       = 1'b0;
        wait (table_ready);
        for (int r = 0; r < row_count; r++) begin
            if (!row_is_cfg[r]) expected_rows.push_back(r);
        end
        forever begin
            // Outputs are settled mid cycle
            @(negedge clock);
            cycles++;
            if (cycles > row_count * cycles_per_row) begin
                stop_run($sformatf("Timeout: run not done after %0d cycles", cycles));
            end
            assert (r_credit == branch_valid)
            else report_mismatch("r_credit", 32'(r_credit), 32'(branch_valid));
            // Upstream credits come back only through r_credit
            if (r_credit) credits_returned++;
            if (branch_valid) begin
                assert (expected_rows.size() != 0)
                else stop_run("branch_valid rose with no result outstanding");
                row = expected_rows.pop_front();
                assert (branch_taken == exp_taken[row])
                else report_mismatch("branch_taken", 32'(branch_taken), 32'(exp_taken[row]));
                assert (branch_slot == exp_slot[row])
                else report_mismatch("branch_slot", 32'(branch_slot), 32'(exp_slot[row]));
                assert (branch_thread == row_thread[row])
                else report_mismatch("branch_thread", 32'(branch_thread), 32'(row_thread[row]));
                results_seen++;
                held--;
            end
            @(posedge clock);
            // Random grants up to the consumer's buffer count
            if (rst_n && held < branch_pkg::out_credits && $urandom_range(2, 0) == 0) begin
                out_credit <= 1'b1;
                held++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

endmodule

//--- verilog.f
+incdir+include
src/branch_pkg.sv
src/branch_cfg_if.sv
src/branch_dispatch.sv
src/sentinel_slot.sv
src/branch_resolve.sv
src/branch_unit.sv
test/branch_unit_tb.sv
